// ==== memory_upload_testdata.txt ====
// Line 0: record count, slot line count, lookup line count (16 bits each), image size (32 bits)
// Records: DDR3 offset (32), header bytes 0..15; slots: idx mapper device ref offset
// Lookups: idx (8) addr (32) size (16) ro (8); last line: ram size, expander enables, MSX type
0009_0008_0005_00004290
00000000_4D535870_25000000_00000000_00000000
00000010_4D535850_01000111_030A0400_00000000
00004020_4D535854_02000100_10020001_00000000
00004030_4D535855_02000100_11020002_00000000
00004040_4D535856_02000100_12020003_00000000
00004050_4D535857_02000200_13020004_00000000
00004060_4D53005C_00000000_77020000_00000000
00004070_4D535860_00000000_00000000_00000000
00004280_4D535850_00000022_05706000_00000000
00_03_11_00_00
01_03_11_00_01
02_FF_22_00_02
03_03_00_00_01
10_10_00_01_00
14_11_00_02_00
18_12_00_03_00
1C_13_00_04_00
00_00000000_0001_01
01_00004000_0001_00
02_00008000_0001_00
03_0000C000_0001_00
04_00010000_0002_00
02_05_02

// ==== list.f ====
+incdir+.
mu_pkg.sv
upload_trigger.sv
fill_pattern.sv
slot_layout_table.sv
upload_sequencer.sv
memory_upload.sv
tb_memory_upload.sv

// ==== Bender.yml ====
package:
  name: memory_upload

export_include_dirs:
  - .

sources:
  - mu_pkg.sv
  - upload_trigger.sv
  - fill_pattern.sv
  - slot_layout_table.sv
  - upload_sequencer.sv
  - memory_upload.sv
  - target: simulation
    files:
      - tb_memory_upload.sv

// ==== tb_memory_upload.sv ====
`timescale 1ns/1ns
`include "mu_cfg.svh"

module tb_memory_upload;

   localparam int          TD_LINES  = 32;
   localparam int          DDR_BYTES = 32768;
   localparam int          RAM_BYTES = 131072;
   localparam logic [15:0] SEED      = 16'd23447;

   logic clk, rst_n, ioctl_download, reload, ddr3_rd, ddr3_ready, ram_ce, sdram_ready;
   logic kbd_request, kbd_we, reset_rq, lookup_ro;
   logic [15:0] ioctl_index, lookup_size;
   logic [3:0] bios_expander_en;
   logic [1:0] bios_msx_typ, slot_offset;
   mu_pkg::ram_addr_t ioctl_addr, ram_addr, lookup_addr;
   mu_pkg::ddr_addr_t ddr3_addr;
   mu_pkg::byte_t ddr3_dout, ram_din, kbd_din, bios_ram_size, slot_mapper, slot_device;
   mu_pkg::kbd_addr_t kbd_addr;
   mu_pkg::block_idx_t slot_idx;
   mu_pkg::ref_ram_t slot_ref_ram, lookup_idx;

   logic [159:0]  td [TD_LINES];   // Records, expected tables, bios values
   mu_pkg::byte_t ddr_mem [DDR_BYTES];
   mu_pkg::byte_t ram_mem [RAM_BYTES];
   mu_pkg::byte_t kbd_mem [`MU_KBD_BYTES];
   int n_rec, n_slot, n_lu, image_len, ram_strobes, kbd_strobes, watch_cycles;
   logic stall_en, ce_last, bit_a, bit_b;
   logic [15:0] stall_st;

   memory_upload dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic lfsr_byte(inout logic [15:0] st, output mu_pkg::byte_t b);
      for (int i = 0; i < 8; i++) begin
         b  = {st[0], b[7:1]};
         st = lfsr_step(st);
      end
   endtask

   task take_bit(output logic b);
      b        = stall_st[0];
      stall_st = lfsr_step(stall_st);
   endtask

   task automatic report_failure(string what);
      $display("%s", what);
      $display("** FAIL **");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
      assert (expected === actual) else
         report_failure($sformatf("Mismatch %s expected %0h actual %0h", name, expected, actual));
   endtask

   function automatic mu_pkg::byte_t hdr_byte(int r, int k);
      return td[1 + r][127 - 8*k -: 8];
   endfunction

   function automatic bit rec_valid(int r);
      return hdr_byte(r, 0) == `MU_SIG0 && hdr_byte(r, 1) == `MU_SIG1 &&
             hdr_byte(r, 2) == `MU_SIG2;
   endfunction

   function automatic int rec_type(int r);
      mu_pkg::byte_t h;
      h = hdr_byte(r, 3);
      return rec_valid(r) ? int'(h[7:4]) : 0;
   endfunction

   function automatic int region_len(int r);   // RAM bytes allocated by a record
      if (rec_type(r) != 5) return 0;
      return int'(hdr_byte(r, 6)) * 16384;
   endfunction

   function automatic int payload_len(int r);   // DDR3 bytes after the header
      if (rec_type(r) == 6) return `MU_KBD_BYTES;
      if (hdr_byte(r, 4) == 8'd1) return region_len(r);
      return 0;
   endfunction

   task automatic build_image();
      logic [15:0] st;
      mu_pkg::byte_t b;
      int offs;
      st = SEED;
      for (int i = 0; i < DDR_BYTES; i++) ddr_mem[i] = 8'h00;
      for (int r = 0; r < n_rec; r++) begin
         offs = int'(td[1 + r][159:128]);
         for (int k = 0; k < 16; k++) ddr_mem[offs + k] = hdr_byte(r, k);
         for (int i = 0; i < payload_len(r); i++) begin
            lfsr_byte(st, b);
            ddr_mem[offs + 16 + i] = b;
         end
      end
   endtask

   task automatic clear_models();
      for (int i = 0; i < RAM_BYTES; i++) ram_mem[i] = 8'h00;
      for (int i = 0; i < `MU_KBD_BYTES; i++) kbd_mem[i] = 8'h00;
      ram_strobes = 0;
      kbd_strobes = 0;
   endtask

   // DDR3, RAM and keyboard models
   always @(posedge clk) begin
      if (ddr3_rd && ddr3_ready) ddr3_dout <= ddr_mem[ddr3_addr[14:0]];
      if (ram_ce) begin
         assert (!ce_last) else report_failure("RAM strobe in two consecutive cycles");
         ram_mem[ram_addr[16:0]] <= ram_din;
         ram_strobes <= ram_strobes + 1;
      end
      ce_last <= ram_ce;
      if (kbd_we) begin
         assert (kbd_request) else report_failure("Keyboard strobe without kbd_request");
         kbd_mem[kbd_addr] <= kbd_din;
         kbd_strobes <= kbd_strobes + 1;
      end
   end

   always @(posedge clk) begin
      #2;
      if (stall_en) begin
         take_bit(bit_a);
         take_bit(bit_b);
         ddr3_ready = ~(bit_a & bit_b);   // Low about one cycle in four
         take_bit(bit_a);
         take_bit(bit_b);
         sdram_ready = ~(bit_a & bit_b);
      end else begin
         ddr3_ready  = 1'b1;
         sdram_ready = 1'b1;
      end
   end

   task automatic run_upload(bit use_reload);
      @(posedge clk);
      #2;
      if (use_reload) begin
         reload = 1'b1;
      end else begin
         ioctl_index    = 16'd1;
         ioctl_addr     = mu_pkg::ram_addr_t'(image_len);
         ioctl_download = 1'b1;
         repeat (4) @(posedge clk);
         #2;
         ioctl_download = 1'b0;
      end
      @(posedge clk);
      #2;
      reload = 1'b0;
      @(posedge clk);
      #2;
      assert (reset_rq) else report_failure("reset_rq did not rise after the trigger");
      while (reset_rq) @(negedge clk);
   endtask

   task automatic check_tables(string run);
      logic [39:0] e;
      logic [63:0] l;
      logic [159:0] bv;
      for (int idx = 0; idx < `MU_SLOT_ENTRIES; idx++) begin
         e = {8'(idx), `MU_MAPPER_UNUSED, `MU_DEVICE_NONE, 16'h0};
         for (int s = 0; s < n_slot; s++)
            if (td[1 + n_rec + s][39:32] == 8'(idx)) e = td[1 + n_rec + s][39:0];
         @(posedge clk);
         #2;
         slot_idx = 6'(idx);
         @(negedge clk);
         check_value($sformatf("%s slot %0d mapper", run, idx), e[31:24], slot_mapper);
         check_value($sformatf("%s slot %0d device", run, idx), e[23:16], slot_device);
         check_value($sformatf("%s slot %0d ref", run, idx), e[15:8], slot_ref_ram);
         check_value($sformatf("%s slot %0d offset", run, idx), e[7:0], slot_offset);
      end
      for (int i = 0; i < n_lu; i++) begin
         l = td[1 + n_rec + n_slot + i][63:0];
         @(posedge clk);
         #2;
         lookup_idx = l[59:56];
         @(negedge clk);
         check_value($sformatf("%s lookup %0d addr", run, i), l[55:24], lookup_addr);
         check_value($sformatf("%s lookup %0d size", run, i), l[23:8], lookup_size);
         check_value($sformatf("%s lookup %0d ro", run, i), l[7:0], lookup_ro);
      end
      bv = td[1 + n_rec + n_slot + n_lu];
      check_value({run, " bios_ram_size"}, bv[23:16], bios_ram_size);
      check_value({run, " bios_expander_en"}, bv[15:8], bios_expander_en);
      check_value({run, " bios_msx_typ"}, bv[7:0], bios_msx_typ);
      check_value({run, " kbd_request"}, 0, kbd_request);
   endtask

   task automatic check_memories(string run);
      logic [15:0] st;
      mu_pkg::byte_t exp;
      int addr, len, p;
      st   = SEED;
      addr = 0;
      for (int r = 0; r < n_rec; r++) begin
         len = region_len(r);
         for (int i = 0; i < len; i++) begin
            p = i % 512;
            if (hdr_byte(r, 4) == 8'd1) lfsr_byte(st, exp);
            else case (hdr_byte(r, 11))
               8'd2:    exp = 8'h00;
               8'd3:    exp = ((p / 256) % 2 != (p / 2) % 2) ? 8'hFF : 8'h00;
               8'd4:    exp = ((p / 256) % 2 != p % 2) ? 8'hFF : 8'h00;
               default: exp = 8'hFF;
            endcase
            check_value($sformatf("%s ram byte %0h", run, addr + i), exp, ram_mem[addr + i]);
         end
         addr += len;
         if (rec_type(r) == 6) begin
            for (int i = 0; i < `MU_KBD_BYTES; i++) begin
               lfsr_byte(st, exp);
               check_value($sformatf("%s kbd byte %0d", run, i), exp, kbd_mem[i]);
            end
         end
      end
      check_value({run, " ram strobes"}, addr, ram_strobes);
      check_value({run, " kbd strobes"}, `MU_KBD_BYTES, kbd_strobes);
   endtask

   initial begin
      int units;
      rst_n = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index = '0;
      ioctl_addr = '0;
      reload = 1'b0;
      ddr3_dout = '0;
      ddr3_ready = 1'b1;
      sdram_ready = 1'b1;
      slot_idx = '0;
      lookup_idx = '0;
      stall_en = 1'b0;
      stall_st = SEED;
      ce_last = 1'b0;
      watch_cycles = 0;
      $readmemh("memory_upload_testdata.txt", td);
      n_rec     = int'(td[0][79:64]);
      n_slot    = int'(td[0][63:48]);
      n_lu      = int'(td[0][47:32]);
      image_len = int'(td[0][31:0]);
      build_image();
      clear_models();
      units = image_len + `MU_SLOT_ENTRIES;
      for (int r = 0; r < n_rec; r++) units += region_len(r);
      watch_cycles = units * 32;   // Two runs, stalls, a few cycles per byte
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      check_value("reset reset_rq", 0, reset_rq);
      check_value("reset ddr3_rd", 0, ddr3_rd);
      check_value("reset ram_ce", 0, ram_ce);
      check_value("reset kbd_we", 0, kbd_we);
      check_value("reset kbd_request", 0, kbd_request);
      check_value("reset bios_ram_size", 0, bios_ram_size);
      check_value("reset bios_expander_en", 0, bios_expander_en);
      check_value("reset bios_msx_typ", 0, bios_msx_typ);
      run_upload(1'b0);
      check_tables("download");
      check_memories("download");
      clear_models();
      stall_en = 1'b1;   // Second pass with ready stalls
      run_upload(1'b1);
      stall_en = 1'b0;
      check_tables("reload");
      check_memories("reload");
      $display("** PASS **");
      $finish;
   end

   initial begin
      wait (watch_cycles > 0);
      repeat (watch_cycles) @(posedge clk);
      report_failure($sformatf("Timeout after %0d cycles, upload never finished", watch_cycles));
   end

endmodule

// ==== memory_upload.sv ====
`timescale 1ns/1ns

module memory_upload (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               ioctl_download,
   input  logic [15:0]        ioctl_index,
   input  mu_pkg::ram_addr_t  ioctl_addr,
   input  logic               reload,
   output mu_pkg::ddr_addr_t  ddr3_addr,
   output logic               ddr3_rd,
   input  mu_pkg::byte_t      ddr3_dout,
   input  logic               ddr3_ready,
   output mu_pkg::ram_addr_t  ram_addr,
   output mu_pkg::byte_t      ram_din,
   output logic               ram_ce,
   input  logic               sdram_ready,
   output logic               kbd_request,
   output mu_pkg::kbd_addr_t  kbd_addr,
   output mu_pkg::byte_t      kbd_din,
   output logic               kbd_we,
   output logic               reset_rq,
   output mu_pkg::byte_t      bios_ram_size,
   output logic [3:0]         bios_expander_en,
   output logic [1:0]         bios_msx_typ,
   input  mu_pkg::block_idx_t slot_idx,
   output mu_pkg::byte_t      slot_mapper,
   output mu_pkg::byte_t      slot_device,
   output mu_pkg::ref_ram_t   slot_ref_ram,
   output logic [1:0]         slot_offset,
   input  mu_pkg::ref_ram_t   lookup_idx,
   output mu_pkg::ram_addr_t  lookup_addr,
   output logic [15:0]        lookup_size,
   output logic               lookup_ro
);

   logic               load;
   mu_pkg::ddr_addr_t  image_size;
   mu_pkg::fill_pat_t  pattern;
   mu_pkg::ram_addr_t  region_start;
   logic               clean_stb;
   mu_pkg::block_idx_t clean_idx;
   logic               store_stb;
   logic [3:0]         slot_sub;
   mu_pkg::byte_t      mode;
   mu_pkg::byte_t      param;
   mu_pkg::byte_t      mapper;
   mu_pkg::byte_t      device;
   mu_pkg::ref_ram_t   ref_ram;
   logic               rom_none;

   upload_trigger trig0 (
      .clk, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .reload,
      .load, .image_size
   );

   upload_sequencer seq0 (
      .clk, .rst_n, .load, .image_size, .ddr3_dout, .ddr3_ready, .sdram_ready,
      .lookup_idx, .ddr3_addr, .ddr3_rd, .ram_addr, .ram_ce, .pattern, .region_start,
      .kbd_request, .kbd_addr, .kbd_din, .kbd_we,
      .clean_stb, .clean_idx, .store_stb, .slot_sub, .mode, .param, .mapper, .device,
      .ref_ram, .rom_none, .lookup_addr, .lookup_size, .lookup_ro,
      .bios_ram_size, .bios_expander_en, .bios_msx_typ, .reset_rq
   );

   fill_pattern fill0 (
      .pattern, .ram_addr, .region_start, .ddr_data(ddr3_dout), .ram_din
   );

   slot_layout_table slots0 (
      .clk, .rst_n, .clean_stb, .clean_idx, .store_stb, .slot_sub, .mode, .param,
      .mapper, .device, .ref_ram, .rom_none, .rd_idx(slot_idx),
      .rd_mapper(slot_mapper), .rd_device(slot_device), .rd_ref_ram(slot_ref_ram),
      .rd_offset(slot_offset)
   );

endmodule

// ==== upload_sequencer.sv ====
`timescale 1ns/1ns
`include "mu_cfg.svh"

module upload_sequencer (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               load,
   input  mu_pkg::ddr_addr_t  image_size,
   input  mu_pkg::byte_t      ddr3_dout,
   input  logic               ddr3_ready,
   input  logic               sdram_ready,
   input  mu_pkg::ref_ram_t   lookup_idx,
   output mu_pkg::ddr_addr_t  ddr3_addr,
   output logic               ddr3_rd,
   output mu_pkg::ram_addr_t  ram_addr,
   output logic               ram_ce,
   output mu_pkg::fill_pat_t  pattern,
   output mu_pkg::ram_addr_t  region_start,
   output logic               kbd_request,
   output mu_pkg::kbd_addr_t  kbd_addr,
   output mu_pkg::byte_t      kbd_din,
   output logic               kbd_we,
   output logic               clean_stb,
   output mu_pkg::block_idx_t clean_idx,
   output logic               store_stb,
   output logic [3:0]         slot_sub,
   output mu_pkg::byte_t      mode,
   output mu_pkg::byte_t      param,
   output mu_pkg::byte_t      mapper,
   output mu_pkg::byte_t      device,
   output mu_pkg::ref_ram_t   ref_ram,
   output logic               rom_none,
   output mu_pkg::ram_addr_t  lookup_addr,
   output logic [15:0]        lookup_size,
   output logic               lookup_ro,
   output mu_pkg::byte_t      bios_ram_size,
   output logic [3:0]         bios_expander_en,
   output logic [1:0]         bios_msx_typ,
   output logic               reset_rq
);

   mu_pkg::upload_state_t state;
   mu_pkg::byte_t         hdr [`MU_HDR_BYTES];
   logic [3:0]            hdr_idx;
   logic                  step;
   logic                  sig_ok;
   mu_pkg::data_id_t      data_id;
   logic [10:0]           rec_units;
   mu_pkg::data_size_t    rec_size;
   mu_pkg::data_size_t    remain;
   mu_pkg::ram_addr_t     lu_addr [`MU_LOOKUP_ENTRIES];
   logic [15:0]           lu_size [`MU_LOOKUP_ENTRIES];
   logic                  lu_ro   [`MU_LOOKUP_ENTRIES];

   assign step      = ddr3_ready & ~ddr3_rd;   // DDR3 idle, byte on ddr3_dout
   assign sig_ok    = {hdr[0], hdr[1], hdr[2]} == {`MU_SIG0, `MU_SIG1, `MU_SIG2};
   assign data_id   = mu_pkg::data_id_t'(hdr[`MU_BYTE_DATA_ID]);
   assign rec_units = {hdr[`MU_BYTE_SIZE_HI][2:0], hdr[`MU_BYTE_SIZE_LO]};
   assign rec_size  = mu_pkg::data_size_t'(rec_units) << `MU_BLOCK_SHIFT;

   assign slot_sub  = hdr[`MU_BYTE_TYPE][3:0];
   assign mode      = hdr[`MU_BYTE_MODE];
   assign param     = hdr[`MU_BYTE_PARAM];
   assign mapper    = hdr[`MU_BYTE_MAPPER];
   assign device    = hdr[`MU_BYTE_DEVICE];
   assign rom_none  = data_id == mu_pkg::ROM_NONE;

   assign clean_stb = (state == mu_pkg::ST_CLEAN) & step;
   assign store_stb = (state == mu_pkg::ST_STORE) & step;
   assign reset_rq  = state != mu_pkg::ST_IDLE;

   assign lookup_addr = lu_addr[lookup_idx];
   assign lookup_size = lu_size[lookup_idx];
   assign lookup_ro   = lu_ro[lookup_idx];

   always_ff @(posedge clk) begin
      if (state == mu_pkg::ST_READ_BYTE && step && !load) hdr[hdr_idx] <= ddr3_dout;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state            <= mu_pkg::ST_IDLE;
         ddr3_addr        <= '0;
         ddr3_rd          <= 1'b0;
         ram_addr         <= '0;
         ram_ce           <= 1'b0;
         pattern          <= mu_pkg::PAT_DDR;
         region_start     <= '0;
         kbd_request      <= 1'b0;
         kbd_addr         <= '0;
         kbd_din          <= '0;
         kbd_we           <= 1'b0;
         clean_idx        <= '0;
         hdr_idx          <= '0;
         remain           <= '0;
         ref_ram          <= '0;
         bios_ram_size    <= '0;
         bios_expander_en <= '0;
         bios_msx_typ     <= '0;
         for (int i = 0; i < `MU_LOOKUP_ENTRIES; i++) begin
            lu_addr[i] <= '0;
            lu_size[i] <= '0;
            lu_ro[i]   <= 1'b0;
         end
      end else begin
         if (ram_ce) begin
            ram_ce   <= 1'b0;
            ram_addr <= ram_addr + 1'b1;
         end
         if (kbd_we) begin
            kbd_we   <= 1'b0;
            kbd_addr <= kbd_addr + 1'b1;
            if (kbd_addr == 9'(`MU_KBD_BYTES - 1)) kbd_request <= 1'b0;
         end
         if (ddr3_ready & ddr3_rd) begin   // Read accepted
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
         end
         if (load) begin
            state         <= mu_pkg::ST_CLEAN;
            ddr3_addr     <= '0;
            ddr3_rd       <= 1'b0;
            ram_addr      <= '0;
            ram_ce        <= 1'b0;
            kbd_request   <= 1'b0;
            kbd_we        <= 1'b0;
            clean_idx     <= '0;
            ref_ram       <= '0;
            bios_ram_size <= '0;
         end else if (step) begin
            case (state)
               mu_pkg::ST_CLEAN: begin
                  clean_idx <= clean_idx + 1'b1;
                  if (clean_idx == 6'(`MU_SLOT_ENTRIES - 1)) state <= mu_pkg::ST_READ_HDR;
               end
               mu_pkg::ST_READ_HDR: begin
                  if (ddr3_addr >= image_size) begin
                     state <= mu_pkg::ST_IDLE;   // Image done
                  end else begin
                     ddr3_rd <= 1'b1;
                     hdr_idx <= '0;
                     state   <= mu_pkg::ST_READ_BYTE;
                  end
               end
               mu_pkg::ST_READ_BYTE: begin
                  hdr_idx <= hdr_idx + 1'b1;
                  if (hdr_idx == 4'(`MU_HDR_BYTES - 1)) state <= mu_pkg::ST_CHECK;
                  else ddr3_rd <= 1'b1;
               end
               mu_pkg::ST_CHECK: begin
                  state <= mu_pkg::ST_READ_HDR;   // Bad signature skips the record
                  if (sig_ok) begin
                     case (mu_pkg::config_typ_t'(hdr[`MU_BYTE_TYPE][7:4]))
                        mu_pkg::CONFIG_CONFIG: begin
                           bios_expander_en <= hdr[`MU_BYTE_DATA_ID][3:0];
                           bios_msx_typ     <= hdr[`MU_BYTE_DATA_ID][5:4];
                        end
                        mu_pkg::CONFIG_KBD_LAYOUT: begin
                           kbd_addr    <= '0;
                           kbd_request <= 1'b1;
                           ddr3_rd     <= 1'b1;   // Prefetch
                           state       <= mu_pkg::ST_FILL_KBD;
                        end
                        mu_pkg::CONFIG_SLOT_INTERNAL: begin
                           state <= mu_pkg::ST_ALLOC;
                           if (data_id == mu_pkg::ROM_RAM &&
                               bios_ram_size < hdr[`MU_BYTE_SIZE_LO])
                              bios_ram_size <= hdr[`MU_BYTE_SIZE_LO];
                        end
                        default: ;
                     endcase
                  end
               end
               mu_pkg::ST_ALLOC: begin
                  state <= mu_pkg::ST_STORE;
                  if (rec_size != '0) begin
                     lu_addr[ref_ram] <= ram_addr;
                     lu_size[ref_ram] <= 16'(rec_units);
                     lu_ro[ref_ram]   <= data_id == mu_pkg::ROM_ROM;
                     region_start     <= ram_addr;
                     remain           <= rec_size;
                     state            <= mu_pkg::ST_FILL_RAM;
                     if (data_id == mu_pkg::ROM_ROM) begin
                        pattern <= mu_pkg::PAT_DDR;
                        ddr3_rd <= 1'b1;   // Prefetch
                     end else begin
                        pattern <= mu_pkg::fill_pat_t'(hdr[`MU_BYTE_PATTERN][2:0]);
                     end
                  end
               end
               mu_pkg::ST_FILL_RAM: begin
                  if (sdram_ready & ~ram_ce) begin
                     ram_ce <= 1'b1;
                     remain <= remain - 1'b1;
                     if (remain == mu_pkg::data_size_t'(1)) state <= mu_pkg::ST_STORE;
                     else if (data_id == mu_pkg::ROM_ROM) ddr3_rd <= 1'b1;
                  end
               end
               mu_pkg::ST_STORE: begin
                  ref_ram <= ref_ram + 4'(rec_size != '0);   // Next lookup entry if one was used
                  state   <= mu_pkg::ST_READ_HDR;
               end
               mu_pkg::ST_FILL_KBD: begin
                  kbd_din <= ddr3_dout;
                  kbd_we  <= 1'b1;
                  if (kbd_addr == 9'(`MU_KBD_BYTES - 1)) state <= mu_pkg::ST_READ_HDR;
                  else ddr3_rd <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

// ==== slot_layout_table.sv ====
`timescale 1ns/1ns
`include "mu_cfg.svh"

module slot_layout_table (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               clean_stb,
   input  mu_pkg::block_idx_t clean_idx,
   input  logic               store_stb,
   input  logic [3:0]         slot_sub,
   input  mu_pkg::byte_t      mode,
   input  mu_pkg::byte_t      param,
   input  mu_pkg::byte_t      mapper,
   input  mu_pkg::byte_t      device,
   input  mu_pkg::ref_ram_t   ref_ram,
   input  logic               rom_none,
   input  mu_pkg::block_idx_t rd_idx,
   output mu_pkg::byte_t      rd_mapper,
   output mu_pkg::byte_t      rd_device,
   output mu_pkg::ref_ram_t   rd_ref_ram,
   output logic [1:0]         rd_offset
);

   mu_pkg::byte_t    tab_mapper [`MU_SLOT_ENTRIES];
   mu_pkg::byte_t    tab_device [`MU_SLOT_ENTRIES];
   mu_pkg::ref_ram_t tab_ref    [`MU_SLOT_ENTRIES];
   logic [1:0]       tab_offset [`MU_SLOT_ENTRIES];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `MU_SLOT_ENTRIES; i++) begin
            tab_mapper[i] <= '0;
            tab_device[i] <= '0;
            tab_ref[i]    <= '0;
            tab_offset[i] <= '0;
         end
      end else if (clean_stb) begin
         tab_mapper[clean_idx] <= `MU_MAPPER_UNUSED;
         tab_device[clean_idx] <= `MU_DEVICE_NONE;
         tab_ref[clean_idx]    <= '0;
         tab_offset[clean_idx] <= '0;
      end else if (store_stb) begin
         // Two mode and param bits per 16 KB block
         for (int b = 0; b < 4; b++) begin
            case (mode[2*b +: 2])
               2'd1: begin   // Mirror of a sibling block
                  tab_mapper[{slot_sub, 2'(b)}] <= tab_mapper[{slot_sub, param[2*b +: 2]}];
                  tab_device[{slot_sub, 2'(b)}] <= `MU_DEVICE_NONE;
                  tab_ref[{slot_sub, 2'(b)}]    <= tab_ref[{slot_sub, param[2*b +: 2]}];
                  tab_offset[{slot_sub, 2'(b)}] <= tab_offset[{slot_sub, param[2*b +: 2]}];
               end
               2'd2, 2'd3: begin
                  tab_mapper[{slot_sub, 2'(b)}] <= mode[2*b] ? `MU_MAPPER_UNUSED : mapper;
                  tab_device[{slot_sub, 2'(b)}] <= device;
                  tab_ref[{slot_sub, 2'(b)}]    <= rom_none ? '0 : ref_ram;
                  tab_offset[{slot_sub, 2'(b)}] <= param[2*b +: 2];
               end
               default: ;   // Block untouched
            endcase
         end
      end
   end

   assign rd_mapper  = tab_mapper[rd_idx];
   assign rd_device  = tab_device[rd_idx];
   assign rd_ref_ram = tab_ref[rd_idx];
   assign rd_offset  = tab_offset[rd_idx];

endmodule

// ==== fill_pattern.sv ====
`timescale 1ns/1ns

module fill_pattern (
   input  mu_pkg::fill_pat_t pattern,
   input  mu_pkg::ram_addr_t ram_addr,
   input  mu_pkg::ram_addr_t region_start,
   input  mu_pkg::byte_t     ddr_data,
   output mu_pkg::byte_t     ram_din
);

   mu_pkg::ram_addr_t offs;
   logic [8:0]        pos;

   assign offs = ram_addr - region_start;
   assign pos  = offs[8:0];   // Position within a 512 byte period

   always_comb begin
      case (pattern)
         mu_pkg::PAT_DDR:     ram_din = ddr_data;
         mu_pkg::PAT_FF:      ram_din = 8'hFF;
         mu_pkg::PAT_00:      ram_din = 8'h00;
         mu_pkg::PAT_CHECK_A: ram_din = (pos[8] == ~pos[1]) ? 8'hFF : 8'h00;
         mu_pkg::PAT_CHECK_B: ram_din = (pos[8] != pos[0]) ? 8'hFF : 8'h00;
         default:             ram_din = 8'hFF;
      endcase
   end

endmodule

// ==== upload_trigger.sv ====
`timescale 1ns/1ns

module upload_trigger (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              ioctl_download,
   input  logic [15:0]       ioctl_index,
   input  mu_pkg::ram_addr_t ioctl_addr,
   input  logic              reload,
   output logic              load,
   output mu_pkg::ddr_addr_t image_size
);

   logic download_last;
   logic image_done;

   // Download of the configuration image just ended
   assign image_done = download_last & ~ioctl_download & (ioctl_index[5:0] == 6'd1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         download_last <= 1'b0;
         load          <= 1'b0;
      end else begin
         download_last <= ioctl_download;
         load          <= reload | image_done;
      end
   end

   always_ff @(posedge clk) begin
      if (image_done) image_size <= mu_pkg::ddr_addr_t'(ioctl_addr);   // Final byte count
   end

endmodule

// ==== mu_pkg.sv ====
package mu_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [27:0] ddr_addr_t;
   typedef logic [26:0] ram_addr_t;
   typedef logic [24:0] data_size_t;
   typedef logic [5:0]  block_idx_t;   // Slot, subslot, block
   typedef logic [3:0]  ref_ram_t;
   typedef logic [8:0]  kbd_addr_t;

   typedef enum logic [3:0] {
      CONFIG_SLOT_INTERNAL = 4'd5,
      CONFIG_KBD_LAYOUT    = 4'd6,
      CONFIG_CONFIG        = 4'd7
   } config_typ_t;

   typedef enum logic [7:0] {
      ROM_NONE = 8'd0,
      ROM_ROM  = 8'd1,
      ROM_RAM  = 8'd2
   } data_id_t;

   typedef enum logic [2:0] {
      PAT_DDR     = 3'd0,
      PAT_FF      = 3'd1,
      PAT_00      = 3'd2,
      PAT_CHECK_A = 3'd3,
      PAT_CHECK_B = 3'd4
   } fill_pat_t;

   typedef enum logic [3:0] {
      ST_IDLE, ST_CLEAN, ST_READ_HDR, ST_READ_BYTE, ST_CHECK,
      ST_ALLOC, ST_FILL_RAM, ST_STORE, ST_FILL_KBD
   } upload_state_t;

endpackage

// ==== mu_cfg.svh ====
`ifndef MU_CFG_SVH
`define MU_CFG_SVH

// Configuration record
`define MU_HDR_BYTES        16
`define MU_SIG0             8'h4D   // "M"
`define MU_SIG1             8'h53   // "S"
`define MU_SIG2             8'h58   // "X"

`define MU_BYTE_TYPE        3       // Type hi nibble, slot/subslot lo nibble
`define MU_BYTE_DATA_ID     4       // Data id, or expander/MSX type for config
`define MU_BYTE_SIZE_HI     5
`define MU_BYTE_SIZE_LO     6
`define MU_BYTE_DEVICE      7
`define MU_BYTE_MAPPER      8
`define MU_BYTE_MODE        9
`define MU_BYTE_PARAM       10
`define MU_BYTE_PATTERN     11

`define MU_BLOCK_SHIFT      14      // 16 KB units
`define MU_KBD_BYTES        512

// Table sizes and cleared codes
`define MU_SLOT_ENTRIES     64
`define MU_LOOKUP_ENTRIES   16
`define MU_MAPPER_UNUSED    8'hFF
`define MU_DEVICE_NONE      8'h00

`endif
